// ==== list.f ====
+incdir+test
src/fetch_pkg.sv
src/fetch_stage.sv
src/imem_apb_master.sv
src/branch_predictor.sv
src/fetch_unit.sv
test/tb_fetch_unit.sv

// ==== src/branch_predictor.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Direct-mapped branch target buffer with 2-bit saturating counters
// Combinational lookup on the fetch PC, registered update from execute
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module branch_predictor (
  input  logic             CLK,
  input  logic             nRST,
  // Lookup from fetch
  input  fetch_pkg::word_t lookup_pc,
  output logic             predict_taken,
  output fetch_pkg::word_t predict_target,
  // Update from execute
  input  logic             upd_en,
  input  logic             upd_taken,
  input  fetch_pkg::word_t upd_pc,
  input  fetch_pkg::word_t upd_target
);
  import fetch_pkg::*;

  logic                 btb_valid  [BTB_ENTRIES];
  logic [BTB_TAG_W-1:0] btb_tag    [BTB_ENTRIES];
  word_t                btb_target [BTB_ENTRIES];
  logic [1:0]           btb_cnt    [BTB_ENTRIES];

  logic [BTB_IDX_W-1:0] look_idx;
  logic [BTB_TAG_W-1:0] look_tag;
  logic                 look_hit;
  logic [BTB_IDX_W-1:0] upd_idx;
  logic [BTB_TAG_W-1:0] upd_tag;
  logic                 upd_hit;

  // Index above the byte offset
  assign look_idx = lookup_pc[BTB_IDX_W+1:2];
  assign look_tag = lookup_pc[31:BTB_IDX_W+2];
  assign upd_idx  = upd_pc[BTB_IDX_W+1:2];
  assign upd_tag  = upd_pc[31:BTB_IDX_W+2];

  assign look_hit = btb_valid[look_idx] && (btb_tag[look_idx] == look_tag);
  assign upd_hit  = btb_valid[upd_idx] && (btb_tag[upd_idx] == upd_tag);

  // Taken on a hit with counter in the upper half
  assign predict_taken  = look_hit & btb_cnt[look_idx][1];
  assign predict_target = btb_target[look_idx];

  // Valid bits, allocation on a taken miss
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < BTB_ENTRIES; i++) begin
        btb_valid[i] <= 1'b0;
      end
    end else if (upd_en && !upd_hit && upd_taken) begin
      btb_valid[upd_idx] <= 1'b1;
    end
  end

  // Entry contents
  always_ff @(posedge CLK) begin
    if (upd_en) begin
      if (upd_hit) begin
        // Saturating step toward the outcome
        if (upd_taken) begin
          if (btb_cnt[upd_idx] != 2'b11) begin
            btb_cnt[upd_idx] <= btb_cnt[upd_idx] + 2'b01;
          end
          btb_target[upd_idx] <= upd_target;
        end else if (btb_cnt[upd_idx] != 2'b00) begin
          btb_cnt[upd_idx] <= btb_cnt[upd_idx] - 2'b01;
        end
      end else if (upd_taken) begin
        // Fresh entry, weakly taken
        btb_tag[upd_idx]    <= upd_tag;
        btb_target[upd_idx] <= upd_target;
        btb_cnt[upd_idx]    <= BTB_CNT_INIT;
      end
    end
  end

endmodule

// ==== src/fetch_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch front end shared definitions
// Word type, reset vector, BTB geometry and APB requester state codes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package fetch_pkg;

  // Machine word for PCs, addresses and instructions
  typedef logic [31:0] word_t;

  // PC loaded out of reset
  localparam word_t RESET_PC = 32'h0000_0200;

  // Direct-mapped BTB
  localparam int BTB_ENTRIES = 16;
  localparam int BTB_IDX_W   = $clog2(BTB_ENTRIES);
  // Index sits above the byte offset, tag takes the rest
  localparam int BTB_TAG_W   = 32 - BTB_IDX_W - 2;

  // Weakly taken value given to a freshly allocated entry
  localparam logic [1:0] BTB_CNT_INIT = 2'b10;

  // APB requester states
  localparam logic [1:0] APB_IDLE   = 2'b00;
  localparam logic [1:0] APB_SETUP  = 2'b01;
  localparam logic [1:0] APB_ACCESS = 2'b10;

endpackage

// ==== src/fetch_stage.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch stage of the two-stage RV32I pipeline
// Holds the PC, picks the next PC, drives the instruction read request
// and loads the fetch/execute register with a one-entry stall buffer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fetch_stage (
  input  logic             CLK,
  input  logic             nRST,
  // Execute side control
  input  logic             ex_stall,
  input  logic             redirect,
  input  logic             trap,
  input  fetch_pkg::word_t redirect_addr,
  input  fetch_pkg::word_t trap_pc,
  // Branch predictor
  input  logic             predict_taken,
  input  fetch_pkg::word_t predict_target,
  output fetch_pkg::word_t lookup_pc,
  // Instruction read requester
  output logic             ren,
  output fetch_pkg::word_t addr,
  input  logic             busy,
  input  logic             done,
  input  fetch_pkg::word_t rdata,
  // Fetch/execute register
  output logic             fe_valid,
  output fetch_pkg::word_t fe_pc,
  output fetch_pkg::word_t fe_pc4,
  output fetch_pkg::word_t fe_instr,
  output logic             fe_pred_taken,
  // Misaligned fetch fault
  output logic             mal_insn,
  output fetch_pkg::word_t mal_addr
);
  import fetch_pkg::*;

  word_t pc;
  word_t pc4;
  word_t npc;
  word_t req_addr;
  word_t hold_instr;
  word_t pred_target_q;
  logic  pred_taken_q;
  logic  discard;
  logic  hold_valid;
  logic  flush;
  logic  misaligned;
  logic  fetch_ok;
  logic  fetch_hit;
  logic  advance;
  logic  req_start;

  assign flush      = trap | redirect;
  assign pc4        = pc + 32'd4;
  assign misaligned = (pc[1:0] != 2'b00);
  assign lookup_pc  = pc;

  // Good data this cycle unless the transfer was overtaken
  assign fetch_hit = done & ~discard;
  // PC moves on once the word reaches execute
  assign advance   = ~ex_stall & (fetch_hit | hold_valid);

  // Next PC by priority of trap, redirect, prediction and sequential
  always_comb begin
    if (trap) begin
      npc = trap_pc;
    end else if (redirect) begin
      npc = redirect_addr;
    end else if (pred_taken_q) begin
      npc = pred_target_q;
    end else begin
      npc = pc4;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= RESET_PC;
    end else if (flush || advance) begin
      pc <= npc;
    end
  end

  // New request only with an empty buffer and an aligned PC
  assign fetch_ok = ~misaligned & ~hold_valid & ~flush & ~done;
  // Request stays up for the whole transfer
  assign ren      = busy | fetch_ok;
  assign req_start = ren & ~busy;

  // Address frozen while the transfer is outstanding
  assign addr = busy ? req_addr : pc;

  always_ff @(posedge CLK) begin
    req_addr <= addr;
  end

  // Prediction for the fetched PC sampled at request
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pred_taken_q <= 1'b0;
    end else if (req_start) begin
      pred_taken_q <= predict_taken;
    end
  end

  always_ff @(posedge CLK) begin
    if (req_start) begin
      pred_target_q <= predict_target;
    end
  end

  // Transfer in flight across a redirect is finished and dropped
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      discard <= 1'b0;
    end else if (flush && busy) begin
      discard <= 1'b1;
    end else if (done) begin
      discard <= 1'b0;
    end
  end

  // One-entry buffer for a word that arrives during a stall
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      hold_valid <= 1'b0;
    end else if (flush) begin
      hold_valid <= 1'b0;
    end else if (fetch_hit && ex_stall) begin
      hold_valid <= 1'b1;
    end else if (!ex_stall) begin
      hold_valid <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (fetch_hit && ex_stall) begin
      hold_instr <= rdata;
    end
  end

  // Fetch/execute register control
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      fe_valid      <= 1'b0;
      fe_pred_taken <= 1'b0;
    end else if (flush) begin
      fe_valid <= 1'b0;
    end else if (!ex_stall) begin
      // Bubble when nothing arrived
      fe_valid      <= fetch_hit | hold_valid;
      fe_pred_taken <= pred_taken_q;
    end
  end

  // Payload takes the buffered word first
  always_ff @(posedge CLK) begin
    if (advance) begin
      fe_pc    <= pc;
      fe_pc4   <= pc4;
      fe_instr <= hold_valid ? hold_instr : rdata;
    end
  end

  // Fault holds until the PC is replaced
  assign mal_insn = misaligned;
  assign mal_addr = pc;

  // Steady request address that still belongs to the current PC
  a_addr_stable : assert property (
    @(posedge CLK) disable iff (!nRST) busy |-> $stable(addr) && (discard || (addr == pc))
  );

  // Redirected path needs three cycles before a word reaches execute
  a_flush_bubble : assert property (
    @(posedge CLK) disable iff (!nRST)
      fe_valid |-> !$past(flush) && !$past(flush, 2) && !$past(flush, 3)
  );

endmodule

// ==== src/fetch_unit.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction fetch front end
// Fetch stage, branch target buffer and APB instruction read port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fetch_unit (
  input  logic             CLK,
  input  logic             nRST,
  // Execute side
  input  logic             ex_stall,
  input  logic             redirect,
  input  fetch_pkg::word_t redirect_addr,
  input  logic             trap,
  input  fetch_pkg::word_t trap_pc,
  // Predictor update
  input  logic             upd_en,
  input  fetch_pkg::word_t upd_pc,
  input  logic             upd_taken,
  input  fetch_pkg::word_t upd_target,
  // APB instruction port
  output logic             psel,
  output logic             penable,
  output logic             pwrite,
  output fetch_pkg::word_t paddr,
  input  fetch_pkg::word_t prdata,
  input  logic             pready,
  // Fetch/execute register
  output logic             fe_valid,
  output fetch_pkg::word_t fe_pc,
  output fetch_pkg::word_t fe_pc4,
  output fetch_pkg::word_t fe_instr,
  output logic             fe_pred_taken,
  // Fetch fault
  output logic             mal_insn,
  output fetch_pkg::word_t mal_addr
);
  import fetch_pkg::*;

  // Fetch to predictor
  word_t lookup_pc;
  logic  predict_taken;
  word_t predict_target;
  // Fetch to APB requester
  logic  ren;
  word_t addr;
  logic  busy;
  logic  done;
  word_t rdata;

  fetch_stage fetch_stage_i (
    .CLK            (CLK),
    .nRST           (nRST),
    .ex_stall       (ex_stall),
    .redirect       (redirect),
    .trap           (trap),
    .redirect_addr  (redirect_addr),
    .trap_pc        (trap_pc),
    .predict_taken  (predict_taken),
    .predict_target (predict_target),
    .lookup_pc      (lookup_pc),
    .ren            (ren),
    .addr           (addr),
    .busy           (busy),
    .done           (done),
    .rdata          (rdata),
    .fe_valid       (fe_valid),
    .fe_pc          (fe_pc),
    .fe_pc4         (fe_pc4),
    .fe_instr       (fe_instr),
    .fe_pred_taken  (fe_pred_taken),
    .mal_insn       (mal_insn),
    .mal_addr       (mal_addr)
  );

  branch_predictor branch_predictor_i (
    .CLK            (CLK),
    .nRST           (nRST),
    .lookup_pc      (lookup_pc),
    .predict_taken  (predict_taken),
    .predict_target (predict_target),
    .upd_en         (upd_en),
    .upd_taken      (upd_taken),
    .upd_pc         (upd_pc),
    .upd_target     (upd_target)
  );

  imem_apb_master imem_apb_master_i (
    .CLK     (CLK),
    .nRST    (nRST),
    .ren     (ren),
    .addr    (addr),
    .busy    (busy),
    .done    (done),
    .rdata   (rdata),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .prdata  (prdata),
    .pready  (pready)
  );

endmodule

// ==== src/imem_apb_master.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB requester for instruction fetch
// Turns one read request into a setup cycle and one or more access cycles
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module imem_apb_master (
  input  logic             CLK,
  input  logic             nRST,
  // Fetch side
  input  logic             ren,
  input  fetch_pkg::word_t addr,
  output logic             busy,
  output logic             done,
  output fetch_pkg::word_t rdata,
  // APB side
  output logic             psel,
  output logic             penable,
  output logic             pwrite,
  output fetch_pkg::word_t paddr,
  input  fetch_pkg::word_t prdata,
  input  logic             pready
);
  import fetch_pkg::*;

  logic [1:0] state;
  logic [1:0] next_state;

  always_comb begin
    next_state = state;
    case (state)
      APB_IDLE: begin
        if (ren) begin
          next_state = APB_SETUP;
        end
      end
      APB_SETUP: begin
        next_state = APB_ACCESS;
      end
      APB_ACCESS: begin
        // Wait states until the completer answers
        if (pready) begin
          next_state = APB_IDLE;
        end
      end
      default: begin
        next_state = APB_IDLE;
      end
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= APB_IDLE;
    end else begin
      state <= next_state;
    end
  end

  // Address captured on entry to setup
  always_ff @(posedge CLK) begin
    if (state == APB_IDLE && ren) begin
      paddr <= addr;
    end
  end

  assign psel    = (state != APB_IDLE);
  assign penable = (state == APB_ACCESS);
  // Read only port
  assign pwrite  = 1'b0;

  // Completion pulse in the ready access cycle
  assign done  = penable & pready;
  assign busy  = psel & ~done;
  assign rdata = prdata;

  // Access only ever follows a selected cycle
  a_penable_psel : assert property (
    @(posedge CLK) disable iff (!nRST) penable |-> psel && $past(psel)
  );

  // Bus address matches the held request until the ready access cycle
  a_paddr_stable : assert property (
    @(posedge CLK) disable iff (!nRST) busy |-> (paddr == addr)
  );

endmodule

// ==== test/fetch_ref_model.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model for the fetch front end testbench
// Memory contents, BTB copy and the expected instruction stream
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Constant mixed into every memory word
localparam word_t MEM_KEY = 32'h5a3c_96e1;

// BTB copy, one slot per direct-mapped entry
logic                 m_valid  [BTB_ENTRIES];
logic [BTB_TAG_W-1:0] m_tag    [BTB_ENTRIES];
word_t                m_target [BTB_ENTRIES];
int                   m_cnt    [BTB_ENTRIES];

// Update driven last cycle, visible to lookups one edge later
logic  pend_en;
logic  pend_taken;
word_t pend_pc;
word_t pend_target;

// Live fetched words waiting for execute, oldest first
word_t q_addr   [$];
logic  q_pred   [$];
word_t q_target [$];

// Next PC expected at the execute side
word_t exp_pc;
// Fault expected on the current fetch address
logic  exp_mal;
word_t exp_mal_addr;

// Memory word: address XOR key, rotated left by 7
function automatic word_t mem_word(input word_t a);
  word_t x;
  x = a ^ MEM_KEY;
  return {x[24:0], x[31:25]};
endfunction

function automatic int btb_index(input word_t pc);
  return int'(pc[BTB_IDX_W+1:2]);
endfunction

function automatic logic btb_hit(input word_t pc);
  int i;
  i = btb_index(pc);
  return m_valid[i] && (m_tag[i] == pc[31:BTB_IDX_W+2]);
endfunction

// Taken when the counter sits at 2 or 3
function automatic logic btb_taken(input word_t pc);
  return btb_hit(pc) && (m_cnt[btb_index(pc)] >= 2);
endfunction

task automatic btb_write(input word_t pc, input logic taken, input word_t target);
  int i;
  i = btb_index(pc);
  if (btb_hit(pc)) begin
    if (taken) begin
      m_cnt[i]    = (m_cnt[i] < 3) ? m_cnt[i] + 1 : 3;
      m_target[i] = target;
    end else begin
      m_cnt[i] = (m_cnt[i] > 0) ? m_cnt[i] - 1 : 0;
    end
  end else if (taken) begin
    // Taken miss allocates, weakly taken
    m_valid[i]  = 1'b1;
    m_tag[i]    = pc[31:BTB_IDX_W+2];
    m_target[i] = target;
    m_cnt[i]    = 2;
  end
endtask

task automatic model_reset();
  for (int i = 0; i < BTB_ENTRIES; i++) begin
    m_valid[i] = 1'b0;
    m_cnt[i]   = 0;
  end
  pend_en = 1'b0;
  q_addr.delete();
  q_pred.delete();
  q_target.delete();
  exp_pc       = RESET_PC;
  exp_mal      = 1'b0;
  exp_mal_addr = '0;
endtask

// ==== test/tb_fetch_unit.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the instruction fetch front end
// Random execute traffic and an APB memory checked against a model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_fetch_unit;
  import fetch_pkg::*;

  localparam int NUM_INSNS  = 2000;
  localparam int MAX_CYCLES = NUM_INSNS * 12;

  logic  CLK;
  logic  nRST;
  logic  ex_stall;
  logic  redirect;
  word_t redirect_addr;
  logic  trap;
  word_t trap_pc;
  logic  upd_en;
  word_t upd_pc;
  logic  upd_taken;
  word_t upd_target;
  logic  psel;
  logic  penable;
  logic  pwrite;
  word_t paddr;
  word_t prdata;
  logic  pready;
  logic  fe_valid;
  word_t fe_pc;
  word_t fe_pc4;
  word_t fe_instr;
  logic  fe_pred_taken;
  logic  mal_insn;
  word_t mal_addr;

  `include "fetch_ref_model.svh"

  int unsigned seed;
  int    insn_count;
  int    check_count;
  int    error_count;
  int    pred_count;
  int    redirect_count;
  int    trap_count;
  // APB wait states left in the current transfer
  int    wait_left;
  logic  random_traffic;
  logic  inj_redirect;
  word_t inj_addr;
  // Transfer in flight as seen on the bus
  logic  xfer_drop;
  logic  xfer_pred;
  word_t xfer_addr;
  word_t xfer_target;
  logic  flushed;

  fetch_unit fetch_unit_i (.*);

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  task automatic check_word(input string name, input word_t got, input word_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAILED %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic log_error(input string msg);
    error_count++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  // Aligned address inside a window of words
  function automatic word_t random_word_addr(input word_t base, input int unsigned words);
    return base + (($urandom % words) << 2);
  endfunction

  task automatic drive_inputs();
    // APB memory, 0 to 3 wait states per transfer
    pready = 1'b0;
    prdata = $urandom;
    if (psel && !penable) begin
      wait_left = $urandom % 4;
    end else if (psel && penable) begin
      if (wait_left == 0) begin
        pready = 1'b1;
        prdata = mem_word(paddr);
      end else begin
        wait_left--;
      end
    end
    // Small region so BTB entries alias, 0x1200 hits same indexes
    redirect_addr = random_word_addr(32'h200, 64);
    trap_pc       = random_word_addr(32'h100, 16);
    upd_pc        = random_word_addr((($urandom % 4) == 0) ? 32'h1200 : 32'h200, 64);
    upd_target    = random_word_addr(32'h200, 64);
    upd_taken     = ($urandom % 100) < 65;
    if (random_traffic) begin
      ex_stall = ($urandom % 100) < 30;
      redirect = ($urandom % 100) < 5;
      trap     = ($urandom % 100) < 2;
      upd_en   = ($urandom % 100) < 15;
    end else begin
      ex_stall = 1'b0;
      trap     = 1'b0;
      upd_en   = 1'b0;
      redirect = inj_redirect;
      if (inj_redirect) begin
        redirect_addr = inj_addr;
      end
    end
  endtask

  // Execute takes the register content at an unstalled edge
  task automatic consume_output();
    if (q_addr.size() == 0) begin
      log_error($sformatf("valid output at PC 0x%08h with no fetch outstanding", fe_pc));
    end else begin
      check_word("paddr", q_addr[0], exp_pc);
      check_word("fe_pc", fe_pc, exp_pc);
      check_word("fe_pc4", fe_pc4, exp_pc + 32'd4);
      check_word("fe_instr", fe_instr, mem_word(exp_pc));
      check_bit("fe_pred_taken", fe_pred_taken, q_pred[0]);
      if (q_pred[0]) begin
        pred_count++;
      end
      exp_pc = q_pred[0] ? q_target[0] : exp_pc + 32'd4;
      void'(q_addr.pop_front());
      void'(q_pred.pop_front());
      void'(q_target.pop_front());
    end
    insn_count++;
  endtask

  // Sampled mid-cycle, everything here acts at the next edge
  task automatic observe();
    logic  flush;
    word_t target;
    flush  = trap || redirect;
    target = trap ? trap_pc : redirect_addr;
    if (penable) begin
      check_bit("psel", psel, 1'b1);
    end
    check_bit("pwrite", pwrite, 1'b0);
    if (psel && !penable) begin
      if (exp_mal) begin
        log_error("APB setup issued from a misaligned fetch address");
      end
      // Lookup happened last cycle, before the pending update
      xfer_addr   = paddr;
      xfer_pred   = btb_taken(paddr);
      xfer_target = m_target[btb_index(paddr)];
      xfer_drop   = flush;
    end else if (psel && penable) begin
      check_word("paddr", paddr, xfer_addr);
      xfer_drop = xfer_drop | flush;
    end
    if (flushed) begin
      check_bit("fe_valid", fe_valid, 1'b0);
    end
    if (fe_valid && !ex_stall) begin
      consume_output();
    end
    if (psel && penable && pready && !xfer_drop) begin
      q_addr.push_back(xfer_addr);
      q_pred.push_back(xfer_pred);
      q_target.push_back(xfer_target);
    end
    check_bit("mal_insn", mal_insn, exp_mal);
    if (exp_mal) begin
      check_word("mal_addr", mal_addr, exp_mal_addr);
    end
    // Trap wins over redirect
    if (flush) begin
      q_addr.delete();
      q_pred.delete();
      q_target.delete();
      exp_pc       = target;
      exp_mal      = (target[1:0] != 2'b00);
      exp_mal_addr = target;
      if (trap) begin
        trap_count++;
      end else begin
        redirect_count++;
      end
    end
    flushed = flush;
    if (pend_en) begin
      btb_write(pend_pc, pend_taken, pend_target);
    end
    pend_en     = upd_en;
    pend_taken  = upd_taken;
    pend_pc     = upd_pc;
    pend_target = upd_target;
  endtask

  task automatic run_cycle();
    @(posedge CLK);
    #1;
    drive_inputs();
    @(negedge CLK);
    observe();
  endtask

  task automatic redirect_once(input word_t target);
    inj_redirect = 1'b1;
    inj_addr     = target;
    run_cycle();
    inj_redirect = 1'b0;
  endtask

  initial begin : main_flow
    word_t bad_addr;
    int    start_count;
    seed = 32'h80b1_1a1c;
    void'($urandom(seed));
    nRST          = 1'b0;
    ex_stall      = 1'b0;
    redirect      = 1'b0;
    redirect_addr = '0;
    trap          = 1'b0;
    trap_pc       = '0;
    upd_en        = 1'b0;
    upd_pc        = '0;
    upd_taken     = 1'b0;
    upd_target    = '0;
    prdata        = '0;
    pready        = 1'b0;
    insn_count     = 0;
    check_count    = 0;
    error_count    = 0;
    pred_count     = 0;
    redirect_count = 0;
    trap_count     = 0;
    wait_left      = 0;
    random_traffic = 1'b0;
    inj_redirect   = 1'b0;
    inj_addr       = '0;
    xfer_drop      = 1'b0;
    xfer_pred      = 1'b0;
    xfer_addr      = '0;
    xfer_target    = '0;
    flushed        = 1'b0;
    model_reset();
    repeat (5) @(posedge CLK);
    // Idle bus and empty pipeline while in reset
    check_bit("psel", psel, 1'b0);
    check_bit("penable", penable, 1'b0);
    check_bit("fe_valid", fe_valid, 1'b0);
    check_bit("mal_insn", mal_insn, 1'b0);
    #1;
    nRST = 1'b1;
    random_traffic = 1'b1;
    while (insn_count < NUM_INSNS) begin
      run_cycle();
    end
    // Misaligned redirects on a quiet pipeline
    random_traffic = 1'b0;
    for (int k = 0; k < 4; k++) begin
      bad_addr = 32'h0000_0240 + (k << 4) + (k % 3) + 1;
      redirect_once(bad_addr);
      repeat (12) run_cycle();
      redirect_once(bad_addr & ~32'h3);
      start_count = insn_count;
      while (insn_count == start_count) begin
        run_cycle();
      end
    end
    $display("Checks %0d, errors %0d, instructions %0d, predicted taken %0d, %0d redirects, %0d traps",
             check_count, error_count, insn_count, pred_count, redirect_count, trap_count);
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Run limit from the test length
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge CLK);
      cycles++;
    end
    $display("Timeout after %0d cycles with %0d of %0d instructions checked",
             cycles, insn_count, NUM_INSNS);
    $display("=== FAIL ===");
    $finish;
  end

endmodule
